// File: all.f
source/rom_pkg.sv
source/rom_slot_if.sv
source/rom_slot.sv
source/sdram_arbiter.sv
source/rom_dwnld.sv
source/rom_top.sv
dv/sdram_model.sv
dv/tb_rom_top.sv

// File: Makefile
VERILATOR  = verilator
FLAGS      = --timing --assert --timescale 1ns/100ps
TOP        = tb_rom_top
FILELIST   = all.f
OBJ_DIR    = obj_dir
LOG        = sim.log
FAIL_MSG   = Simulation failed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: dv/tb_rom_top.sv
// ROM subsystem testbench
`default_nettype none

module tb_rom_top import rom_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [31:0] SEED  = 32'hbf82_8726;
    localparam int          LIMIT = 200;   // Cycles allowed per wait
    localparam int          NREAD = 50;

    logic        clk, rst, downloading;
    logic [24:0] ioctl_addr;
    logic [7:0]  ioctl_dout;
    logic        ioctl_wr, prog_we, sdram_req, sdram_ack, data_rdy;
    sdram_addr_t prog_addr, sdram_addr;
    logic [7:0]  prog_data;
    logic [1:0]  prog_mask;
    logic [15:0] data_read;
    logic        scr_cs, obj_cs, main_cs, scr_ok, obj_ok, main_ok;
    logic [12:0] scr_addr, obj_addr;
    logic [15:0] main_addr;
    scr_data_t   scr_data;
    obj_data_t   obj_data;
    main_data_t  main_data;

    logic [31:0] seed;
    int          errors, write_errors, writes, mark, tests_run, tests_failed;
    logic [24:0] last_wr_addr;
    logic        we_d, req_d;
    sdram_addr_t req_log [$];    // Every SDRAM read request in order

    rom_top dut (.*);
    sdram_model #(.SEED(SEED)) u_sdram (.*);

    always #2 clk = ~clk;

    // Byte that the download leaves at one SDRAM byte address
    function automatic logic [7:0] expected_byte(input logic [24:0] b);
        logic [21:0] w;
        logic [21:0] p;
        w = b[22:1];
        p = w;
        if (b >= SCR_START && b < OBJ_START) begin
            p[3]   = ~w[0];
            p[2:0] = w[3:1];
        end else if (b >= OBJ_START && b < PROM_START) begin
            p[3]   = ~w[0];
            p[4]   = w[1];
            p[2:0] = w[4:2];
        end
        return 8'({2'b00, p, b[0]} * 7 + 3);
    endfunction

    function automatic logic [31:0] expected_burst(input logic [24:0] b);
        return {expected_byte(b + 25'd3), expected_byte(b + 25'd2),
                expected_byte(b + 25'd1), expected_byte(b)};
    endfunction

    function automatic int rand_below(input int n);
        logic [31:0] r;
        r = $random(seed);
        return int'(r % 32'(n));
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        errors++;
        $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    endtask

    task automatic fail_check(input string what);
        errors++;
        $display("Error at %0t: %s", $time, what);
    endtask

    task automatic stop_on_timeout(input string what);
        errors++;
        $display("Error at %0t: timed out waiting for %s", $time, what);
        $display("Simulation failed");
        $finish;
    endtask

    task automatic end_test(input int num, input string name);
        tests_run++;
        if (errors + write_errors == mark) begin
            $display("Test %0d, %s: ok", num, name);
        end else begin
            tests_failed++;
            $display("Test %0d, %s: %0d errors", num, name, errors + write_errors - mark);
        end
        mark = errors + write_errors;
    endtask

    task automatic download_byte(input logic [24:0] a);
        int t;
        @(negedge clk);
        ioctl_addr   = a;
        ioctl_dout   = 8'(a * 7 + 3);
        last_wr_addr = a;
        ioctl_wr     = 1'b1;
        @(negedge clk);
        ioctl_wr = 1'b0;
        for (t = 0; prog_we && t < LIMIT; t++) @(negedge clk);
        if (prog_we) stop_on_timeout("prog_we to fall");
    endtask

    task automatic download_region(input logic [24:0] start);
        for (int i = 0; i < 1024; i++) download_byte(start + 25'(i));
    endtask

    // sel bits are scroll, object, main from bit 0 up
    task automatic read_slots(input logic [2:0] sel, input logic [12:0] sa,
                              input logic [12:0] oa, input logic [15:0] ma);
        logic [2:0]  pending;
        logic [31:0] exp;
        int          t;
        @(negedge clk);
        pending   = sel;
        scr_addr  = sa;
        obj_addr  = oa;
        main_addr = ma;
        scr_cs    = sel[0];
        obj_cs    = sel[1];
        main_cs   = sel[2];
        for (t = 0; pending != 3'b000 && t < LIMIT; t++) begin
            @(negedge clk);
            if (pending[0] && scr_ok) begin
                exp = expected_burst(SCR_START + {10'd0, sa, 2'b00});
                if (scr_data !== exp) report_mismatch("scr_data", scr_data, exp);
                scr_cs     = 1'b0;
                pending[0] = 1'b0;
            end
            if (pending[1] && obj_ok) begin
                exp = expected_burst(OBJ_START + {10'd0, oa, 2'b00});
                if (obj_data !== exp) report_mismatch("obj_data", obj_data, exp);
                obj_cs     = 1'b0;
                pending[1] = 1'b0;
            end
            if (pending[2] && main_ok) begin
                exp = {24'd0, expected_byte({9'd0, ma})};
                if ({24'd0, main_data} !== exp) begin
                    report_mismatch("main_data", {24'd0, main_data}, exp);
                end
                main_cs    = 1'b0;
                pending[2] = 1'b0;
            end
        end
        if (pending != 3'b000) stop_on_timeout("ok from a ROM reader");
    endtask

    // Checks each SDRAM write as it starts and logs read requests
    always @(negedge clk) begin : write_watch
        logic [24:0] b;
        we_d  <= prog_we;
        req_d <= sdram_req;
        if (sdram_req && !req_d) req_log.push_back(sdram_addr);
        if (prog_we && !we_d) begin
            writes++;
            b = {2'b00, prog_addr, ~prog_mask[1]};
            if (prog_data !== expected_byte(b)) begin
                write_errors++;
                $display("Mismatch at %0t: prog_data got %h expected %h",
                         $time, prog_data, expected_byte(b));
            end
            if (prog_mask == 2'b00 || prog_mask == 2'b11 || b[24:7] != last_wr_addr[24:7]) begin
                write_errors++;
                $display("Error at %0t: prog_addr %h with prog_mask %b does not fit byte %h",
                         $time, prog_addr, prog_mask, last_wr_addr);
            end
        end
    end

    initial begin
        logic [12:0] sa;
        logic [12:0] oa;
        logic [15:0] ma;
        int          n0;
        int          t;
        $timeformat(-9, 1, " ns", 0);
        seed        = SEED;
        clk         = 1'b0;
        rst         = 1'b1;
        downloading = 1'b0;
        ioctl_addr  = '0;
        ioctl_dout  = '0;
        ioctl_wr    = 1'b0;
        scr_cs      = 1'b0;
        scr_addr    = '0;
        obj_cs      = 1'b0;
        obj_addr    = '0;
        main_cs     = 1'b0;
        main_addr   = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        @(negedge clk);
        downloading = 1'b1;
        download_region(25'h0);
        download_region(SCR_START);
        download_region(OBJ_START);
        @(negedge clk);
        downloading = 1'b0;
        if (writes != 3072) fail_check($sformatf("%0d SDRAM writes instead of 3072", writes));
        end_test(1, "download with address swizzle");

        for (int i = 0; i < NREAD; i++) begin
            ma = 16'(rand_below(1024));
            read_slots(3'b100, '0, '0, ma);
        end
        end_test(2, "random main CPU reads");

        for (int i = 0; i < NREAD; i++) begin
            sa = 13'(rand_below(256));
            read_slots(3'b001, sa, '0, ma);
        end
        for (int i = 0; i < NREAD; i++) begin
            oa = 13'(rand_below(256));
            read_slots(3'b010, sa, oa, ma);
        end
        end_test(3, "random scroll and object reads");

        sa = sa ^ 13'h080; // Fresh bursts make all three miss
        oa = oa ^ 13'h080;
        ma = ma ^ 16'h0200;
        n0 = req_log.size();
        read_slots(3'b111, sa, oa, ma);
        if (req_log.size() < n0 + 3) begin
            fail_check("fewer than three SDRAM reads for three misses");
        end else if (req_log[n0] !== SCR_START[22:1] + {8'd0, sa, 1'b0}) begin
            report_mismatch("sdram_addr", {10'd0, req_log[n0]},
                            {10'd0, SCR_START[22:1] + {8'd0, sa, 1'b0}});
        end
        end_test(4, "three misses in one cycle");

        n0 = req_log.size();
        read_slots(3'b111, sa, oa, ma);
        if (req_log.size() != n0) fail_check("repeated addresses caused new SDRAM reads");
        end_test(5, "cache hits on repeated addresses");

        n0 = req_log.size();
        @(negedge clk);
        downloading = 1'b1;
        scr_cs      = 1'b1;
        obj_cs      = 1'b1;
        main_cs     = 1'b1;
        for (t = 0; t < 40; t++) begin
            @(negedge clk);
            if (sdram_req || scr_ok || obj_ok || main_ok) begin
                fail_check("sdram_req or an ok went high while downloading");
                break;
            end
        end
        scr_cs      = 1'b0;
        obj_cs      = 1'b0;
        main_cs     = 1'b0;
        downloading = 1'b0;
        read_slots(3'b001, sa, oa, ma); // Cache was cleared by the download
        if (req_log.size() != n0 + 1) fail_check("download did not clear the scroll cache");
        end_test(6, "reads held off while downloading");

        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed,
                 errors + write_errors);
        if (errors + write_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: dv/sdram_model.sv
// Behavioral SDRAM with random latency
`default_nettype none

module sdram_model import rom_pkg::*; #(
    parameter int          MEM_AW = 17,          // Byte address bits held
    parameter logic [31:0] SEED   = 32'hbf82_8726
) (
    input  logic        clk,
    input  sdram_addr_t prog_addr,
    input  logic [7:0]  prog_data,
    input  logic [1:0]  prog_mask,   // Active low byte enables
    input  logic        prog_we,
    input  logic        sdram_req,
    input  sdram_addr_t sdram_addr,
    output logic        sdram_ack,
    output logic        data_rdy,
    output logic [15:0] data_read
);

    timeunit 1ns;
    timeprecision 100ps;

    logic [7:0]  mem [1 << MEM_AW];
    logic [31:0] seed;
    logic        is_read;
    sdram_addr_t rd_addr;

    function automatic int pick(input int lo, input int hi);
        logic [31:0] r;
        r = $random(seed);
        return lo + int'(r % 32'(hi - lo + 1));
    endfunction

    // High byte sits at the odd byte address
    function automatic logic [15:0] read_word(input sdram_addr_t w);
        return {mem[{w[MEM_AW-2:0], 1'b1}], mem[{w[MEM_AW-2:0], 1'b0}]};
    endfunction

    initial begin
        seed      = SEED;
        sdram_ack = 1'b0;
        data_rdy  = 1'b0;
        data_read = '0;
        forever begin
            @(negedge clk);
            if (prog_we || sdram_req) begin
                is_read = sdram_req;
                repeat (pick(1, 6) - 1) @(negedge clk);
                if (!is_read && !prog_mask[0]) mem[{prog_addr[MEM_AW-2:0], 1'b0}] = prog_data;
                if (!is_read && !prog_mask[1]) mem[{prog_addr[MEM_AW-2:0], 1'b1}] = prog_data;
                rd_addr   = sdram_addr;
                sdram_ack = 1'b1;
                @(negedge clk);
                sdram_ack = 1'b0;
                for (int i = 0; i < 2 && is_read; i++) begin // Lower word first
                    repeat (pick(0, 3)) @(negedge clk);
                    data_rdy  = 1'b1;
                    data_read = read_word(rd_addr + sdram_addr_t'(i));
                    @(negedge clk);
                    data_rdy  = 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: source/rom_top.sv
// Game ROM subsystem top level
`default_nettype none

module rom_top import rom_pkg::*; #(
    parameter sdram_addr_t SCR_OFFSET  = sdram_addr_t'(SCR_START >> 1),
    parameter sdram_addr_t OBJ_OFFSET  = sdram_addr_t'(OBJ_START >> 1),
    parameter sdram_addr_t MAIN_OFFSET = '0
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        downloading,
    // Download stream
    input  logic [24:0] ioctl_addr,
    input  logic [7:0]  ioctl_dout,
    input  logic        ioctl_wr,
    output sdram_addr_t prog_addr,
    output logic [7:0]  prog_data,
    output logic [1:0]  prog_mask,   // Active low
    output logic        prog_we,
    // SDRAM read port
    output logic        sdram_req,
    output sdram_addr_t sdram_addr,
    input  logic        sdram_ack,
    input  logic        data_rdy,
    input  logic [15:0] data_read,
    // Scroll tiles
    input  logic        scr_cs,
    input  logic [12:0] scr_addr,
    output logic        scr_ok,
    output scr_data_t   scr_data,
    // Object sprites
    input  logic        obj_cs,
    input  logic [12:0] obj_addr,
    output logic        obj_ok,
    output obj_data_t   obj_data,
    // Main CPU program
    input  logic        main_cs,
    input  logic [15:0] main_addr,
    output logic        main_ok,
    output main_data_t  main_data
);

    rom_slot_if scr_if ();
    rom_slot_if obj_if ();
    rom_slot_if main_if ();

    rom_slot #(.payload_t(scr_data_t), .AW(13), .OFFSET(SCR_OFFSET)) u_scr (
        .clk(clk), .rst(rst), .downloading(downloading),
        .cs(scr_cs), .addr(scr_addr), .ok(scr_ok), .dout(scr_data),
        .mem(scr_if.slot)
    );

    rom_slot #(.payload_t(obj_data_t), .AW(13), .OFFSET(OBJ_OFFSET)) u_obj (
        .clk(clk), .rst(rst), .downloading(downloading),
        .cs(obj_cs), .addr(obj_addr), .ok(obj_ok), .dout(obj_data),
        .mem(obj_if.slot)
    );

    rom_slot #(.payload_t(main_data_t), .AW(16), .OFFSET(MAIN_OFFSET)) u_main (
        .clk(clk), .rst(rst), .downloading(downloading),
        .cs(main_cs), .addr(main_addr), .ok(main_ok), .dout(main_data),
        .mem(main_if.slot)
    );

    // Scroll has top priority, the CPU comes last
    sdram_arbiter u_arb (
        .clk(clk), .rst(rst), .downloading(downloading),
        .s0(scr_if.arb), .s1(obj_if.arb), .s2(main_if.arb),
        .sdram_req(sdram_req), .sdram_addr(sdram_addr), .sdram_ack(sdram_ack),
        .data_rdy(data_rdy), .data_read(data_read)
    );

    rom_dwnld u_dwnld (
        .clk(clk), .rst(rst), .downloading(downloading),
        .ioctl_addr(ioctl_addr), .ioctl_dout(ioctl_dout), .ioctl_wr(ioctl_wr),
        .sdram_ack(sdram_ack),
        .prog_addr(prog_addr), .prog_data(prog_data),
        .prog_mask(prog_mask), .prog_we(prog_we)
    );

endmodule

`default_nettype wire

// File: source/rom_dwnld.sv
// Download byte stream to SDRAM writes
`default_nettype none

module rom_dwnld import rom_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        downloading,
    input  logic [24:0] ioctl_addr,
    input  logic [7:0]  ioctl_dout,
    input  logic        ioctl_wr,
    input  logic        sdram_ack,
    output sdram_addr_t prog_addr,
    output logic [7:0]  prog_data,
    output logic [1:0]  prog_mask,
    output logic        prog_we
);

    sdram_addr_t pre_addr;
    sdram_addr_t sw_addr;
    logic        in_scr;
    logic        in_obj;
    logic        store;

    assign pre_addr = ioctl_addr[SDRAM_AW:1]; // Byte to word address
    assign in_scr   = (ioctl_addr >= SCR_START) && (ioctl_addr < OBJ_START);
    assign in_obj   = (ioctl_addr >= OBJ_START) && (ioctl_addr < PROM_START);

    // PROM bytes are dropped here
    assign store = ioctl_wr && downloading && (ioctl_addr < PROM_START);

    // Board wiring of the graphics ROM address lines
    always_comb begin
        sw_addr = pre_addr;
        if (in_scr) begin
            sw_addr[0]   = ~pre_addr[3];
            sw_addr[3:1] =  pre_addr[2:0];
        end
        if (in_obj) begin
            sw_addr[0]   = ~pre_addr[3];
            sw_addr[1]   =  pre_addr[4];
            sw_addr[5:2] =  {pre_addr[5], pre_addr[2:0]};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            prog_we <= 1'b0;
        end else if (prog_we && sdram_ack) begin
            prog_we <= 1'b0;
        end else if (store) begin
            prog_we <= 1'b1; // Held until the SDRAM takes it
        end
    end

    always_ff @(posedge clk) begin
        if (store) begin
            prog_addr <= sw_addr;
            prog_data <= ioctl_dout;
            prog_mask <= ioctl_addr[0] ? 2'b01 : 2'b10; // Active low
        end
    end

    // The loader sends one byte at a time
    assert property (@(posedge clk) disable iff (rst) ioctl_wr |-> !prog_we)
        else $error("rom_dwnld: ioctl_wr while a write is pending");

endmodule

`default_nettype wire

// File: source/sdram_arbiter.sv
// SDRAM read port arbiter
`default_nettype none

module sdram_arbiter import rom_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        downloading,
    rom_slot_if.arb     s0,
    rom_slot_if.arb     s1,
    rom_slot_if.arb     s2,
    output logic        sdram_req,
    output sdram_addr_t sdram_addr,
    input  logic        sdram_ack,
    input  logic        data_rdy,
    input  logic [15:0] data_read
);

    typedef enum logic [1:0] {
        IDLE,
        REQ,    // sdram_req up, waiting for ack
        DATA,   // Collecting two words
        DONE    // Burst handed back
    } state_t;

    state_t     st;
    logic [1:0] owner;
    logic       second;
    burst_t     burst;
    logic       any_req;
    logic       ack_now;

    assign any_req = s0.req || s1.req || s2.req;
    assign ack_now = (st == REQ) && sdram_ack;

    always_ff @(posedge clk) begin
        if (rst) begin
            st        <= IDLE;
            sdram_req <= 1'b0;
            second    <= 1'b0;
        end else begin
            case (st)
                IDLE: begin
                    if (any_req && !downloading) begin
                        sdram_req <= 1'b1;
                        st        <= REQ;
                    end
                end
                REQ: begin
                    if (sdram_ack) begin
                        sdram_req <= 1'b0;
                        second    <= 1'b0;
                        st        <= DATA;
                    end
                end
                DATA: begin
                    if (data_rdy) begin
                        second <= 1'b1;
                        if (second) st <= DONE;
                    end
                end
                default: st <= IDLE; // DONE lasts one cycle
            endcase
        end
    end

    // Owner, address and burst payload
    always_ff @(posedge clk) begin
        if (st == IDLE) begin
            if (s0.req) begin
                owner      <= 2'd0;
                sdram_addr <= s0.addr;
            end else if (s1.req) begin
                owner      <= 2'd1;
                sdram_addr <= s1.addr;
            end else begin
                owner      <= 2'd2;
                sdram_addr <= s2.addr;
            end
        end
        if (st == DATA && data_rdy) begin
            if (second) burst[31:16] <= data_read;
            else        burst[15:0]  <= data_read; // Lower word first
        end
    end

    assign s0.grant = ack_now && (owner == 2'd0);
    assign s1.grant = ack_now && (owner == 2'd1);
    assign s2.grant = ack_now && (owner == 2'd2);

    assign s0.valid = (st == DONE) && (owner == 2'd0);
    assign s1.valid = (st == DONE) && (owner == 2'd1);
    assign s2.valid = (st == DONE) && (owner == 2'd2);

    assign s0.data = burst;
    assign s1.data = burst;
    assign s2.data = burst;

    assert property (@(posedge clk) disable iff (rst) $onehot0({s0.valid, s1.valid, s2.valid}))
        else $error("sdram_arbiter: more than one valid");

    // Reads and download writes must never compete for sdram_ack
    assert property (@(posedge clk) disable iff (rst) downloading |-> !sdram_req)
        else $error("sdram_arbiter: sdram_req during download");

endmodule

`default_nettype wire

// File: source/rom_slot.sv
// ROM reader with one-burst cache
`default_nettype none

module rom_slot import rom_pkg::*; #(
    parameter type         payload_t = burst_t,
    parameter int          AW        = 13,
    parameter sdram_addr_t OFFSET    = '0    // Word address, even
) (
    input  logic          clk,
    input  logic          rst,
    input  logic          downloading,
    input  logic          cs,
    input  logic [AW-1:0] addr,
    output logic          ok,
    output payload_t      dout,
    rom_slot_if.slot      mem
);

    // Byte-wide readers pick one byte out of the burst
    localparam bit BYTE_WIDE = ($bits(payload_t) == 8);

    sdram_addr_t burst_idx;
    sdram_addr_t word_addr;
    sdram_addr_t req_addr;
    sdram_addr_t cache_tag;
    burst_t      cache_data;
    logic        cache_valid;
    logic        req;
    logic        granted;

    sdram_addr_t src_tag;
    burst_t      src_data;
    logic        src_ok;
    logic        hit;
    logic        need;

    always_comb begin
        if (BYTE_WIDE) begin
            burst_idx = sdram_addr_t'(addr >> 2); // Four bytes per burst
        end else begin
            burst_idx = sdram_addr_t'(addr);
        end
    end

    assign word_addr = OFFSET + (burst_idx << 1);

    // A burst arriving now counts as cached already
    assign src_tag  = mem.valid ? req_addr : cache_tag;
    assign src_data = mem.valid ? mem.data : cache_data;
    assign src_ok   = mem.valid || cache_valid;
    assign hit      = src_ok && (src_tag == word_addr);
    assign need     = cs && !hit && !req && !downloading;

    always_ff @(posedge clk) begin
        if (rst) begin
            req         <= 1'b0;
            granted     <= 1'b0;
            cache_valid <= 1'b0;
            ok          <= 1'b0;
        end else begin
            ok <= cs && hit && !downloading;
            if (mem.valid) begin
                req <= 1'b0;
            end else if (need) begin
                req <= 1'b1;
            end
            if (mem.grant) begin
                granted <= 1'b1;
            end else if (mem.valid) begin
                granted <= 1'b0;
            end
            if (downloading) begin
                cache_valid <= 1'b0; // ROM contents are changing
            end else if (mem.valid) begin
                cache_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (need) begin
            req_addr <= word_addr;
        end
        if (mem.valid) begin
            cache_tag  <= req_addr;
            cache_data <= mem.data;
        end
        if (BYTE_WIDE) begin
            dout <= payload_t'(src_data >> {addr[1:0], 3'd0});
        end else begin
            dout <= payload_t'(src_data);
        end
    end

    assign mem.req  = req;
    assign mem.addr = req_addr;

    // Data only comes back for a request the arbiter took
    assert property (@(posedge clk) disable iff (rst) mem.valid |-> granted)
        else $error("rom_slot: valid without a prior grant");

    assert property (@(posedge clk) disable iff (rst) !cs |=> !ok)
        else $error("rom_slot: ok high after cs fell");

endmodule

`default_nettype wire

// File: source/rom_slot_if.sv
// ROM reader to arbiter link
`default_nettype none

interface rom_slot_if import rom_pkg::*; ();

    logic        req;     // Level, held until valid
    sdram_addr_t addr;    // Even word address of the burst
    logic        grant;   // Pulse with sdram_ack
    logic        valid;   // Pulse, data holds the burst
    burst_t      data;

    // Reader side
    modport slot (
        output req,
        output addr,
        input  grant,
        input  valid,
        input  data
    );

    // Arbiter side
    modport arb (
        input  req,
        input  addr,
        output grant,
        output valid,
        output data
    );

endinterface

`default_nettype wire

// File: source/rom_pkg.sv
// ROM loader shared definitions
`default_nettype none

package rom_pkg;

    // SDRAM word addressing
    localparam int SDRAM_AW = 22;

    typedef logic [SDRAM_AW-1:0] sdram_addr_t;

    // Two consecutive 16-bit words, lower address in the lower half
    typedef logic [31:0] burst_t;

    // Region starts in the download byte stream
    localparam logic [24:0] SCR_START  = 25'h01_0000; // Scroll tiles
    localparam logic [24:0] OBJ_START  = 25'h01_8000; // Object sprites
    localparam logic [24:0] PROM_START = 25'h02_0000; // Palette PROMs, not stored

    // Reader payloads
    typedef burst_t      scr_data_t;
    typedef burst_t      obj_data_t;
    typedef logic [7:0]  main_data_t;

endpackage

`default_nettype wire
